//--- Makefile
VERILATOR ?= verilator
TOP       ?= game_control_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/game_control_assertions.sv
// concurrent checks on the phase FSM, bound into every game_fsm instance by the testbench
module game_control_assertions
	import game_pkg::*;
(
	input logic        Clk,
	input logic        arst_n,
	input game_state_t game_state,
	input logic        load_background
);
	timeunit 1ns;
	timeprecision 1ps;

	// failed assertions so far, added into the testbench error count
	int fail_cnt = 0;

	// scene load strobe is a single-cycle pulse
	strobe_one_cycle: assert property (@(posedge Clk) disable iff (!arst_n)
		load_background |=> !load_background)
	else
	begin
		$error("load_background held high for more than one cycle");
		fail_cnt++;
	end

	// first clock out of reset sees the menu
	menu_after_reset: assert property (@(posedge Clk)
		$rose(arst_n) |-> (game_state == ST_MENU))
	else
	begin
		$error("phase is not the menu when reset is released");
		fail_cnt++;
	end

	// paused to running keeps the current scene
	no_strobe_on_start: assert property (@(posedge Clk) disable iff (!arst_n)
		(game_state == ST_ROUND_RUNNING && $past(game_state) == ST_ROUND_PAUSED)
		|-> !load_background)
	else
	begin
		$error("load_background raised when a paused round started running");
		fail_cnt++;
	end

endmodule

//--- sim/game_control_tb.sv
// directed testbench for the game controller, simulation top with the FSM checks bound in
module game_control_tb
	import key_pkg::*;
	import game_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// all DUT inputs, staged on the falling edge and applied on the rising edge
	typedef struct packed {
		logic       arst_n;
		logic [7:0] key_code;
		logic       frame_tick;
		logic       new_game;
		logic       blue_win;
		logic       red_win;
		logic       round_reset;
	} drive_t;

	logic        Clk = 1'b0;
	// staged values and the copy the DUT sees, reset low from time zero
	drive_t      drv = '0;
	drive_t      dut_in = '0;
	game_state_t game_state;
	bg_sel_t     background_select;
	logic        load_background;
	int          err_cnt = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	game_control_top u_game_control_top (
		.Clk               (Clk),
		.arst_n            (dut_in.arst_n),
		.key_code          (dut_in.key_code),
		.frame_tick        (dut_in.frame_tick),
		.new_game          (dut_in.new_game),
		.blue_win          (dut_in.blue_win),
		.red_win           (dut_in.red_win),
		.round_reset       (dut_in.round_reset),
		.game_state        (game_state),
		.background_select (background_select),
		.load_background   (load_background)
	);

	bind game_fsm game_control_assertions u_game_control_assertions (.*);

	// 8 ns clock
	initial
	begin
		forever #4 Clk = ~Clk;
	end

	always @(posedge Clk)
		dut_in <= drv;

	task automatic report(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic check_state(input game_state_t exp, input string what);
		if (game_state !== exp)
			report($sformatf("%s, state %s, expected %s", what, game_state.name(), exp.name()));
	endtask

	task automatic check_bg(input bg_sel_t exp, input string what);
		if (background_select !== exp)
			report($sformatf("%s, background %s, expected %s", what,
				background_select.name(), exp.name()));
	endtask

	task automatic check_load(input bit exp, input string what);
		if (load_background !== exp)
			report($sformatf("%s, load_background %b, expected %b", what, load_background, exp));
	endtask

	// outputs are sampled on the falling edge, one cycle after the press
	task automatic press_key(input logic [7:0] code);
		drv.key_code = code;
		@(negedge Clk);
		// release so the next press of the same key counts again
		drv.key_code = 8'h00;
		@(negedge Clk);
	endtask

	task automatic pulse_tick();
		drv.frame_tick = 1'b1;
		@(negedge Clk);
		drv.frame_tick = 1'b0;
		@(negedge Clk);
	endtask

	// playfield levels held for a single cycle
	task automatic play_events(input logic blue, input logic red, input logic rst);
		drv.blue_win    = blue;
		drv.red_win     = red;
		drv.round_reset = rst;
		@(negedge Clk);
		drv.blue_win    = 1'b0;
		drv.red_win     = 1'b0;
		drv.round_reset = 1'b0;
		@(negedge Clk);
	endtask

	task automatic wait_state(input game_state_t target, input int limit);
		int n;
		n = 0;
		while (game_state != target && n < limit)
		begin
			@(negedge Clk);
			n++;
		end
		if (game_state != target)
		begin
			$display("timeout: state %s not reached within %0d cycles", target.name(), limit);
			err_cnt++;
		end
	endtask

	// new_game goes to the menu without a strobe
	// simultaneous enter would step or strobe unless new_game overrides it
	task automatic force_menu();
		drv.new_game = 1'b1;
		drv.key_code = KEY_ENTER;
		@(negedge Clk);
		drv.new_game = 1'b0;
		drv.key_code = 8'h00;
		@(negedge Clk);
		check_state(ST_MENU, "new_game");
		check_load(1'b0, "new_game");
	endtask

	task automatic start_round();
		press_key(KEY_ENTER);
		press_key(KEY_ENTER);
		wait_state(ST_ROUND_RUNNING, 4);
	endtask

	task automatic note_result(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	task automatic reset_and_enter();
		check_state(ST_MENU, "after reset");
		check_bg(BG_MAP0, "after reset");
		check_load(1'b0, "after reset");
		press_key(KEY_ENTER);
		check_state(ST_ROUND_PAUSED, "enter in menu");
		check_load(1'b1, "enter in menu");
		@(negedge Clk);
		check_load(1'b0, "one cycle after menu exit");
		press_key(KEY_ENTER);
		check_state(ST_ROUND_RUNNING, "enter while paused");
		check_load(1'b0, "enter while paused");
		force_menu();
	endtask

	task automatic held_enter();
		drv.key_code = KEY_ENTER;
		@(negedge Clk);
		@(negedge Clk);
		check_load(1'b1, "enter held, first step");
		// a held key must not keep stepping the phase
		for (int i = 0; i < 16; i++)
		begin
			@(negedge Clk);
			check_state(ST_ROUND_PAUSED, "enter held");
			check_load(1'b0, "enter held");
		end
		drv.key_code = 8'h00;
		@(negedge Clk);
	endtask

	task automatic map_choice();
		force_menu();
		press_key(KEY_DOWN);
		check_bg(BG_MAP0, "down at first map");
		press_key(KEY_UP);
		check_bg(BG_MAP1, "up from first map");
		press_key(KEY_W);
		check_bg(BG_MAP1, "up at last map");
		press_key(KEY_ENTER);
		press_key(KEY_S);
		check_bg(BG_MAP1, "down while paused");
		press_key(KEY_ENTER);
		press_key(KEY_DOWN);
		check_bg(BG_MAP1, "down while running");
		force_menu();
		press_key(KEY_S);
		check_bg(BG_MAP0, "down in menu");
		// up from the first map outside the menu
		press_key(KEY_ENTER);
		press_key(KEY_UP);
		check_bg(BG_MAP0, "up while paused");
		force_menu();
	endtask

	task automatic round_wins();
		start_round();
		// red beats a blue win in the same cycle
		play_events(1'b1, 1'b1, 1'b0);
		check_state(ST_RED_WINS, "red and blue win together");
		check_bg(BG_RED_WIN, "red win");
		check_load(1'b1, "red win");
		press_key(KEY_ENTER);
		check_state(ST_MENU, "enter after red win");
		check_load(1'b1, "enter after red win");
		start_round();
		play_events(1'b1, 1'b0, 1'b0);
		check_state(ST_BLUE_WINS, "blue win");
		check_bg(BG_BLUE_WIN, "blue win");
		check_load(1'b1, "blue win");
		press_key(KEY_ENTER);
		check_state(ST_MENU, "enter after blue win");
		check_load(1'b1, "enter after blue win");
	endtask

	task automatic round_timeout();
		press_key(KEY_ENTER);
		// ticks while paused must not count toward the limit
		repeat (5) pulse_tick();
		press_key(KEY_ENTER);
		repeat (ROUND_FRAMES - 1) pulse_tick();
		check_state(ST_ROUND_RUNNING, "one frame before the limit");
		pulse_tick();
		wait_state(ST_ROUND_PAUSED, 4);
		check_load(1'b1, "round timeout");
	endtask

	task automatic reset_and_new_game();
		press_key(KEY_ENTER);
		play_events(1'b0, 1'b0, 1'b1);
		check_state(ST_ROUND_PAUSED, "round reset");
		check_load(1'b1, "round reset");
		force_menu();
		force_menu();
		start_round();
		force_menu();
		start_round();
		play_events(1'b0, 1'b1, 1'b0);
		force_menu();
	endtask

	initial
	begin
		int errs;
		// reset held over two rising edges
		repeat (2) @(negedge Clk);
		drv.arst_n = 1'b1;
		@(negedge Clk);
		errs = err_cnt;
		reset_and_enter();
		note_result("reset_and_enter", errs);
		errs = err_cnt;
		held_enter();
		note_result("held_enter", errs);
		errs = err_cnt;
		map_choice();
		note_result("map_choice", errs);
		errs = err_cnt;
		round_wins();
		note_result("round_wins", errs);
		errs = err_cnt;
		round_timeout();
		note_result("round_timeout", errs);
		errs = err_cnt;
		reset_and_new_game();
		note_result("reset_and_new_game", errs);
		err_cnt += u_game_control_top.u_game_fsm.u_game_control_assertions.fail_cnt;
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- src.f
src/key_pkg.sv
src/game_pkg.sv
src/key_event_decoder.sv
src/game_fsm.sv
src/round_timer.sv
src/map_select.sv
src/game_control_top.sv
sim/game_control_assertions.sv
sim/game_control_tb.sv

//--- src/game_control_top.sv
// top level of the game controller, wires decoder, phase FSM, round timer and map selector
module game_control_top
	import key_pkg::*;
	import game_pkg::*;
(
	input  logic        Clk,
	input  logic        arst_n,
	input  logic [7:0]  key_code,
	input  logic        frame_tick,
	input  logic        new_game,
	input  logic        blue_win,
	input  logic        red_win,
	input  logic        round_reset,
	output game_state_t game_state,
	output bg_sel_t     background_select,
	output logic        load_background
);

	// press pulses from the keyboard side
	key_events_t   key_events;
	// expiry of the running round
	logic          timeout;
	// playfield levels plus timer expiry
	round_events_t round_events;

	// scan code to press pulses
	key_event_decoder u_key_event_decoder (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.key_code   (key_code),
		.key_events (key_events)
	);

	// bundle everything that can end a round
	assign round_events = '{
		blue_win:    blue_win,
		red_win:     red_win,
		round_reset: round_reset,
		timeout:     timeout
	};

	// phase FSM
	game_fsm u_game_fsm (
		.Clk             (Clk),
		.arst_n          (arst_n),
		.new_game        (new_game),
		.key_events      (key_events),
		.round_events    (round_events),
		.game_state      (game_state),
		.load_background (load_background)
	);

	// round length limit
	round_timer u_round_timer (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.game_state (game_state),
		.frame_tick (frame_tick),
		.timeout    (timeout)
	);

	// map choice and background
	map_select u_map_select (
		.Clk               (Clk),
		.arst_n            (arst_n),
		.game_state        (game_state),
		.key_events        (key_events),
		.background_select (background_select)
	);

endmodule

//--- src/game_fsm.sv
// phase state machine of the arena game, drives the phase and the background load strobe
module game_fsm
	import key_pkg::*;
	import game_pkg::*;
(
	input  logic          Clk,
	input  logic          arst_n,
	input  logic          new_game,
	input  key_events_t   key_events,
	input  round_events_t round_events,
	output game_state_t   game_state,
	output logic          load_background
);

	// current and next phase
	game_state_t state;
	game_state_t next_state;
	// scene change decided this cycle, shows up registered next cycle
	logic        load_next;

	// next phase and scene change decision
	always_comb
	begin
		// default hold, no new scene
		next_state = state;
		load_next  = 1'b0;
		case (state)
			ST_MENU:
			begin
				// leave menu into the first paused round
				if (key_events.enter)
				begin
					next_state = ST_ROUND_PAUSED;
					load_next  = 1'b1;
				end
			end
			ST_ROUND_PAUSED:
			begin
				// start play, scene stays as is
				if (key_events.enter)
				begin
					next_state = ST_ROUND_RUNNING;
				end
			end
			ST_ROUND_RUNNING:
			begin
				// red first, then blue, then reset, then timeout
				if (round_events.red_win)
				begin
					next_state = ST_RED_WINS;
					load_next  = 1'b1;
				end
				else if (round_events.blue_win)
				begin
					next_state = ST_BLUE_WINS;
					load_next  = 1'b1;
				end
				else if (round_events.round_reset || round_events.timeout)
				begin
					// both go back to a paused round on a fresh map
					next_state = ST_ROUND_PAUSED;
					load_next  = 1'b1;
				end
			end
			ST_BLUE_WINS, ST_RED_WINS:
			begin
				// back to the menu after the win screen
				if (key_events.enter)
				begin
					next_state = ST_MENU;
					load_next  = 1'b1;
				end
			end
			default:
			begin
				// unused codes recover to the menu
				next_state = ST_MENU;
			end
		endcase
	end

	// phase register and registered strobe
	// new_game wins over any decision and loads nothing
	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state           <= ST_MENU;
			load_background <= 1'b0;
		end
		else if (new_game)
		begin
			state           <= ST_MENU;
			load_background <= 1'b0;
		end
		else
		begin
			state           <= next_state;
			load_background <= load_next;
		end
	end

	assign game_state = state;

endmodule

//--- src/game_pkg.sv
// game phase, background and round definitions shared by all controller modules
package game_pkg;

	// phases of the game
	// encoding kept in declaration order, menu is zero
	typedef enum logic [2:0] {
		ST_MENU,
		ST_ROUND_PAUSED,
		ST_ROUND_RUNNING,
		ST_BLUE_WINS,
		ST_RED_WINS
	} game_state_t;

	// background images the video side can load
	// map codes come first so a map index maps straight onto them
	typedef enum logic [1:0] {
		BG_MAP0,
		BG_MAP1,
		BG_BLUE_WIN,
		BG_RED_WIN
	} bg_sel_t;

	// playable maps selectable from the menu
	localparam int NUM_MAPS = 2;
	// map index width, at least one bit
	localparam int MAP_IDX_W = (NUM_MAPS > 1) ? $clog2(NUM_MAPS) : 1;

	// frame ticks a round may run before it is cut off
	// small value for simulation
	localparam int ROUND_FRAMES = 8;
	// counter width, holds ROUND_FRAMES itself
	localparam int ROUND_CNT_W = $clog2(ROUND_FRAMES + 1);

	// round-ending events seen by the phase FSM
	typedef struct packed {
		// blue player won the round
		logic blue_win;
		// red player won the round
		logic red_win;
		// playfield asks for a fresh round
		logic round_reset;
		// round timer expired
		logic timeout;
	} round_events_t;

endpackage

//--- src/key_event_decoder.sv
// turns the raw keyboard scan code into one-cycle key press pulses for the game controller
module key_event_decoder
	import key_pkg::*;
(
	input  logic        Clk,
	input  logic        arst_n,
	input  logic [7:0]  key_code,
	output key_events_t key_events
);

	// scan code seen in the previous cycle
	logic [7:0] prev_code;
	// high on the first cycle of a new code
	logic       code_changed;

	// remember the last code for edge detection
	// zero means no key, so a key held through reset still counts once
	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			prev_code <= 8'h00;
		end
		else
		begin
			prev_code <= key_code;
		end
	end

	// any change of code is a candidate press
	assign code_changed = (key_code != prev_code);

	// decode against the game key set
	always_comb
	begin
		key_events = KEY_EVENTS_NONE;
		if (code_changed)
		begin
			// enter only from its own code
			key_events.enter = (key_code == KEY_ENTER);
			// letter or arrow for up
			key_events.up    = (key_code == KEY_W) || (key_code == KEY_UP);
			// letter or arrow for down
			key_events.down  = (key_code == KEY_S) || (key_code == KEY_DOWN);
		end
	end

endmodule

//--- src/key_pkg.sv
// keyboard scan codes and key event type, imported by the decoder and its consumers
package key_pkg;

	// scan codes of the keys the game reacts to
	// enter advances the game phase
	localparam logic [7:0] KEY_ENTER = 8'h28;

	// map selection up, letter and arrow
	localparam logic [7:0] KEY_W     = 8'h1a;
	localparam logic [7:0] KEY_UP    = 8'h52;

	// map selection down, letter and arrow
	localparam logic [7:0] KEY_S     = 8'h16;
	localparam logic [7:0] KEY_DOWN  = 8'h51;

	// one-cycle press pulses
	// each bit fires once per press, never on hold
	typedef struct packed {
		// enter pressed
		logic enter;
		// w or up arrow pressed
		logic up;
		// s or down arrow pressed
		logic down;
	} key_events_t;

	// idle value, no key pressed this cycle
	localparam key_events_t KEY_EVENTS_NONE = '{
		enter: 1'b0,
		up:    1'b0,
		down:  1'b0
	};

endpackage

//--- src/map_select.sv
// map chooser for the menu, turns the phase and chosen map into a background selection
module map_select
	import key_pkg::*;
	import game_pkg::*;
(
	input  logic        Clk,
	input  logic        arst_n,
	input  game_state_t game_state,
	input  key_events_t key_events,
	output bg_sel_t     background_select
);

	// chosen map
	logic [MAP_IDX_W-1:0] map_idx;
	// index limits
	logic                 at_top;
	logic                 at_bottom;

	assign at_top    = (map_idx == MAP_IDX_W'(NUM_MAPS - 1));
	assign at_bottom = (map_idx == '0);

	// up and down only move the index in the menu
	// saturating at both ends, up wins if both arrive together
	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			map_idx <= '0;
		end
		else if (game_state == ST_MENU)
		begin
			if (key_events.up && !at_top)
			begin
				map_idx <= map_idx + 1'b1;
			end
			else if (key_events.down && !at_bottom)
			begin
				map_idx <= map_idx - 1'b1;
			end
		end
	end

	// win screens override the map
	always_comb
	begin
		case (game_state)
			ST_BLUE_WINS: background_select = BG_BLUE_WIN;
			ST_RED_WINS:  background_select = BG_RED_WIN;
			// map codes start at zero, index maps straight across
			default:      background_select = bg_sel_t'($bits(bg_sel_t)'(map_idx));
		endcase
	end

endmodule

//--- src/round_timer.sv
// frame-counting round timer, pulses timeout when a running round reaches its frame limit
module round_timer
	import game_pkg::*;
(
	input  logic        Clk,
	input  logic        arst_n,
	input  game_state_t game_state,
	input  logic        frame_tick,
	output logic        timeout
);

	// frames elapsed in the current round
	logic [ROUND_CNT_W-1:0] frame_cnt;
	// round currently in play
	logic                   running;
	// this tick is the last one allowed
	logic                   last_frame;

	assign running    = (game_state == ST_ROUND_RUNNING);
	assign last_frame = (frame_cnt == ROUND_CNT_W'(ROUND_FRAMES - 1));

	// expiry in the same cycle as the final tick
	assign timeout = running && frame_tick && last_frame;

	// count ticks only while running
	// any other phase clears, so each round starts a fresh limit
	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			frame_cnt <= '0;
		end
		else if (!running)
		begin
			frame_cnt <= '0;
		end
		else if (frame_tick)
		begin
			// wrap on expiry, the FSM leaves running next cycle anyway
			if (last_frame)
			begin
				frame_cnt <= '0;
			end
			else
			begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

endmodule
